// ==== Makefile ====
# Verilator build and run for the execute stage testbench.

VERILATOR  ?= verilator
TOP        := tb_exu_top
FILELIST   := tb.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail.
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

    // ******************************
    // operation encodings.
    // ******************************

    // operand pair for the alu, as (a, b).
    typedef enum logic [1:0] {
        SRC_ZERO_IMM = 2'b00,
        SRC_PC_IMM   = 2'b01,
        SRC_RS1_RS2  = 2'b10,
        SRC_RS1_IMM  = 2'b11
    } src_sel_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_XOR  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_AND  = 3'd4,
        ALU_SLT  = 3'd5,
        ALU_SLTU = 3'd6,
        ALU_SLL  = 3'd7
    } alu_fn_t;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_LOAD  = 2'b01,
        MEM_STORE = 2'b10
    } mem_kind_t;

    // encoding 2'b11 is unused and gives an empty byte mask.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_BRANCH = 2'b01,
        PC_JAL    = 2'b10,
        PC_JALR   = 2'b11
    } pc_sel_t;

    // one decoded operation, 12 bits.
    typedef struct packed {
        src_sel_t  src_sel;
        alu_fn_t   alu_fn;
        mem_kind_t mem_kind;
        mem_size_t mem_size;
        pc_sel_t   pc_sel;
        logic      ebreak;
    } exu_op_t;

    // ******************************
    // data memory.
    // ******************************

    // 256 words, indexed by byte address bits 9:2.
    localparam int MEM_DEPTH   = 256;
    localparam int MEM_ADDR_W  = 8;
    // cycles from request to acknowledge.
    localparam int MEM_LATENCY = 3;

endpackage

`default_nettype wire

// ==== common/mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// four-phase link from the load/store unit to the data memory.
interface mem_if;
    logic                          req;
    logic                          ack;
    logic                          we;
    // word address.
    logic [exu_pkg::MEM_ADDR_W-1:0] addr;
    logic [31:0]                   wdata;
    logic [3:0]                    wmask;
    logic [31:0]                   rdata;

    // load/store side.
    modport master (
        output req, we, addr, wdata, wmask,
        input  ack, rdata
    );

    // memory side.
    modport slave (
        input  req, we, addr, wdata, wmask,
        output ack, rdata
    );
endinterface

`default_nettype wire

// ==== lsu/exu_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_data_ram (
    input  wire  clk,
    input  wire  rst_n,
    mem_if.slave mem
);

    logic [31:0] ram [exu_pkg::MEM_DEPTH];
    logic        wait_en;
    logic        expired;
    logic        hit;

    // latency runs while a request waits for its answer.
    assign wait_en = mem.req && !mem.ack;
    assign hit     = wait_en && expired;

    exu_wait_timer #(
        .WIDTH (4)
    ) i_exu_wait_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (wait_en),
        .expired (expired)
    );

    // ******************************
    // storage and acknowledge.
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.ack <= 1'b0;
            // memory comes up zeroed.
            for (int i = 0; i < exu_pkg::MEM_DEPTH; i++) begin
                ram[i] <= 32'd0;
            end
        end else begin
            if (hit) begin
                mem.ack <= 1'b1;
                // write lands with the rising ack.
                if (mem.we) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem.wmask[b]) begin
                            ram[mem.addr][b*8 +: 8] <= mem.wdata[b*8 +: 8];
                        end
                    end
                end
            end else if (mem.ack && !mem.req) begin
                mem.ack <= 1'b0;
            end
        end
    end

    // read word stays put while ack is high.
    always_ff @(posedge clk) begin
        if (hit) begin
            mem.rdata <= ram[mem.addr];
        end
    end

endmodule

`default_nettype wire

// ==== lsu/exu_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_lsu (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     start,
    input  wire exu_pkg::mem_kind_t kind,
    input  wire exu_pkg::mem_size_t size,
    input  wire [31:0]              addr,
    input  wire [31:0]              store_data,
    output logic                    done,
    output logic [31:0]             load_data,
    mem_if.master                   mem
);

    logic [3:0]         base_mask;
    logic [1:0]         lane;
    exu_pkg::mem_size_t lat_size;
    logic [31:0]        shifted;

    // byte width before the lane shift.
    always_comb begin
        case (size)
            exu_pkg::SIZE_BYTE: base_mask = 4'b0001;
            exu_pkg::SIZE_HALF: base_mask = 4'b0011;
            exu_pkg::SIZE_WORD: base_mask = 4'b1111;
            default:            base_mask = 4'b0000;
        endcase
    end

    // ******************************
    // request payload, held for the access.
    // ******************************
    always_ff @(posedge clk) begin
        if (start) begin
            mem.we    <= (kind == exu_pkg::MEM_STORE);
            mem.addr  <= addr[exu_pkg::MEM_ADDR_W+1:2];
            mem.wmask <= base_mask << addr[1:0];
            // store data moves up into its lane.
            mem.wdata <= store_data << {addr[1:0], 3'b000};
            lane      <= addr[1:0];
            lat_size  <= size;
        end
    end

    // ******************************
    // four-phase master side.
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem.req <= 1'b0;
        end else if (start) begin
            mem.req <= 1'b1;
        end else if (mem.req && mem.ack) begin
            // release the request once the memory answers.
            mem.req <= 1'b0;
        end
    end

    // high only in the cycle ack rises.
    assign done = mem.req && mem.ack;

    // load data moves down from its lane, zero extended.
    assign shifted = mem.rdata >> {lane, 3'b000};

    always_comb begin
        case (lat_size)
            exu_pkg::SIZE_BYTE: load_data = {24'd0, shifted[7:0]};
            exu_pkg::SIZE_HALF: load_data = {16'd0, shifted[15:0]};
            default:            load_data = shifted;
        endcase
    end

endmodule

`default_nettype wire

// ==== lsu/exu_wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_wait_timer #(
    parameter int WIDTH = 4
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  enable,
    output logic expired
);

    logic [WIDTH-1:0] count;

    // reload while idle, count down while enabled.
    always_ff @(posedge clk) begin
        if (!rst_n || !enable) begin
            count   <= WIDTH'(exu_pkg::MEM_LATENCY - 1);
            expired <= 1'b0;
        end else if (count == '0) begin
            // sticks until enable drops.
            expired <= 1'b1;
        end else begin
            count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
    input  wire exu_pkg::exu_op_t op,
    input  wire [31:0]           rs1_d,
    input  wire [31:0]           rs2_d,
    input  wire [31:0]           imm,
    input  wire [31:0]           pc,
    output logic [31:0]          res
);

    logic [31:0] var1;
    logic [31:0] var2;

    // operand select.
    always_comb begin
        case (op.src_sel)
            exu_pkg::SRC_ZERO_IMM: begin
                var1 = 32'd0;
                var2 = imm;
            end
            exu_pkg::SRC_PC_IMM: begin
                var1 = pc;
                var2 = imm;
            end
            exu_pkg::SRC_RS1_RS2: begin
                var1 = rs1_d;
                var2 = rs2_d;
            end
            default: begin
                var1 = rs1_d;
                var2 = imm;
            end
        endcase
    end

    // function select, compares give 0 or 1.
    always_comb begin
        case (op.alu_fn)
            exu_pkg::ALU_ADD:  res = var1 + var2;
            exu_pkg::ALU_SUB:  res = var1 - var2;
            exu_pkg::ALU_XOR:  res = var1 ^ var2;
            exu_pkg::ALU_OR:   res = var1 | var2;
            exu_pkg::ALU_AND:  res = var1 & var2;
            exu_pkg::ALU_SLT:  res = {31'd0, $signed(var1) < $signed(var2)};
            exu_pkg::ALU_SLTU: res = {31'd0, var1 < var2};
            // shift amount is the low five bits.
            default:           res = var1 << var2[4:0];
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   op_req,
    input  wire exu_pkg::exu_op_t op,
    input  wire [31:0]            rs1_d,
    input  wire [31:0]            rs2_d,
    input  wire [31:0]            imm,
    input  wire [31:0]            pc,
    input  wire [31:0]            alu_res,
    input  wire [31:0]            next_pc,
    input  wire                   lsu_done,
    input  wire [31:0]            lsu_rdata,
    output logic                  op_ack,
    output exu_pkg::exu_op_t      lat_op,
    output logic [31:0]           lat_rs1,
    output logic [31:0]           lat_rs2,
    output logic [31:0]           lat_imm,
    output logic [31:0]           lat_pc,
    output logic                  lsu_start,
    output logic [31:0]           rd_d,
    output logic [31:0]           dnpc,
    output logic                  halt,
    output logic [31:0]           halt_code
);

    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        MEM,
        ACK,
        RELEASE
    } state_t;

    state_t state;
    logic   is_mem;

    // ebreak suppresses any memory access.
    assign is_mem = (lat_op.mem_kind != exu_pkg::MEM_NONE) && !lat_op.ebreak;

    // one-cycle start while the alu result is the address.
    assign lsu_start = (state == EXEC) && is_mem;

    // ******************************
    // operand latch.
    // ******************************
    always_ff @(posedge clk) begin
        if (state == IDLE && op_req) begin
            lat_op  <= op;
            lat_rs1 <= rs1_d;
            lat_rs2 <= rs2_d;
            lat_imm <= imm;
            lat_pc  <= pc;
        end
    end

    // ******************************
    // sequencer.
    // ******************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            op_ack    <= 1'b0;
            halt      <= 1'b0;
            halt_code <= 32'd0;
        end else begin
            case (state)
                IDLE: begin
                    if (op_req) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (is_mem) begin
                        state <= MEM;
                    end else begin
                        rd_d   <= alu_res;
                        dnpc   <= next_pc;
                        op_ack <= 1'b1;
                        state  <= ACK;
                    end
                    // halt is sticky until reset.
                    if (lat_op.ebreak) begin
                        halt      <= 1'b1;
                        halt_code <= lat_rs1;
                    end
                end
                MEM: begin
                    // stores return the address.
                    if (lsu_done) begin
                        rd_d   <= (lat_op.mem_kind == exu_pkg::MEM_LOAD) ? lsu_rdata : alu_res;
                        dnpc   <= next_pc;
                        op_ack <= 1'b1;
                        state  <= ACK;
                    end
                end
                ACK: begin
                    // results hold while the source keeps op_req high.
                    if (!op_req) begin
                        state <= RELEASE;
                    end
                end
                default: begin
                    op_ack <= 1'b0;
                    state  <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exu_next_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_next_pc (
    input  wire exu_pkg::exu_op_t op,
    input  wire [31:0]           rs1_d,
    input  wire [31:0]           imm,
    input  wire [31:0]           pc,
    input  wire [31:0]           alu_res,
    output logic [31:0]          next_pc
);

    logic [31:0] ina;
    logic [31:0] inb;
    logic [31:0] sum;
    logic        taken;

    // branch is taken on any nonzero compare result.
    assign taken = |alu_res;

    always_comb begin
        case (op.pc_sel)
            exu_pkg::PC_SEQ: begin
                ina = pc;
                inb = 32'd4;
            end
            exu_pkg::PC_BRANCH: begin
                ina = pc;
                inb = taken ? imm : 32'd4;
            end
            exu_pkg::PC_JAL: begin
                ina = pc;
                inb = imm;
            end
            default: begin
                ina = rs1_d;
                inb = imm;
            end
        endcase
    end

    assign sum = ina + inb;

    // jalr target has bit 0 cleared.
    assign next_pc = (op.pc_sel == exu_pkg::PC_JALR) ? {sum[31:1], 1'b0} : sum;

endmodule

`default_nettype wire

// ==== rtl/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   op_req,
    input  wire exu_pkg::exu_op_t op,
    input  wire [31:0]            rs1_d,
    input  wire [31:0]            rs2_d,
    input  wire [31:0]            imm,
    input  wire [31:0]            pc,
    output logic                  op_ack,
    output logic [31:0]           rd_d,
    output logic [31:0]           dnpc,
    output logic                  halt,
    output logic [31:0]           halt_code
);

    exu_pkg::exu_op_t lat_op;
    logic [31:0]      lat_rs1;
    logic [31:0]      lat_rs2;
    logic [31:0]      lat_imm;
    logic [31:0]      lat_pc;
    logic [31:0]      alu_res;
    logic [31:0]      next_pc;
    logic             lsu_start;
    logic             lsu_done;
    logic [31:0]      lsu_rdata;

    mem_if i_mem_if ();

    // ******************************
    // control.
    // ******************************
    exu_ctrl i_exu_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_req    (op_req),
        .op        (op),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .alu_res   (alu_res),
        .next_pc   (next_pc),
        .lsu_done  (lsu_done),
        .lsu_rdata (lsu_rdata),
        .op_ack    (op_ack),
        .lat_op    (lat_op),
        .lat_rs1   (lat_rs1),
        .lat_rs2   (lat_rs2),
        .lat_imm   (lat_imm),
        .lat_pc    (lat_pc),
        .lsu_start (lsu_start),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt      (halt),
        .halt_code (halt_code)
    );

    // ******************************
    // datapath.
    // ******************************
    exu_alu i_exu_alu (
        .op    (lat_op),
        .rs1_d (lat_rs1),
        .rs2_d (lat_rs2),
        .imm   (lat_imm),
        .pc    (lat_pc),
        .res   (alu_res)
    );

    exu_next_pc i_exu_next_pc (
        .op      (lat_op),
        .rs1_d   (lat_rs1),
        .imm     (lat_imm),
        .pc      (lat_pc),
        .alu_res (alu_res),
        .next_pc (next_pc)
    );

    // ******************************
    // memory subsystem.
    // ******************************
    // the alu result is the byte address.
    exu_lsu i_exu_lsu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (lsu_start),
        .kind       (lat_op.mem_kind),
        .size       (lat_op.mem_size),
        .addr       (alu_res),
        .store_data (lat_rs2),
        .done       (lsu_done),
        .load_data  (lsu_rdata),
        .mem        (i_mem_if.master)
    );

    exu_data_ram i_exu_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (i_mem_if.slave)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
common/exu_pkg.sv
common/mem_if.sv
lsu/exu_wait_timer.sv
lsu/exu_data_ram.sv
lsu/exu_lsu.sv
rtl/exu_alu.sv
rtl/exu_next_pc.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
testbench/tb_exu_top.sv

// ==== testbench/tb_exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int OP_LIMIT      = 600;
    localparam int CYCLES_PER_OP = 40;
    localparam int WORDS         = 256;
    localparam int STORES        = 48;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             op_req;
    exu_pkg::exu_op_t op;
    logic [31:0]      rs1_d;
    logic [31:0]      rs2_d;
    logic [31:0]      imm;
    logic [31:0]      pc;
    logic             op_ack;
    logic [31:0]      rd_d;
    logic [31:0]      dnpc;
    logic             halt;
    logic [31:0]      halt_code;

    // model state.
    logic [31:0] rng_state;
    logic [31:0] shadow [WORDS];
    logic        exp_halt;
    logic [31:0] exp_code;
    int          errors;
    int          checks;

    // handshake monitor state, sampled at the rising edge.
    logic        req_q1;
    logic        req_q2;
    logic        rst_q1;
    logic        ack_prev;
    logic [31:0] rd_prev;
    logic [31:0] dnpc_prev;
    int          hs_errors = 0;

    exu_top i_exu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_req    (op_req),
        .op        (op),
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .imm       (imm),
        .pc        (pc),
        .op_ack    (op_ack),
        .rd_d      (rd_d),
        .dnpc      (dnpc),
        .halt      (halt),
        .halt_code (halt_code)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ******************************
    // model helpers.
    // ******************************

    // xorshift32 step.
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic exu_pkg::exu_op_t build_op(input logic [1:0] src, input logic [2:0] fn,
            input logic [1:0] kind, input logic [1:0] size, input logic [1:0] psel,
            input logic brk);
        exu_pkg::exu_op_t o;
        o.src_sel  = exu_pkg::src_sel_t'(src);
        o.alu_fn   = exu_pkg::alu_fn_t'(fn);
        o.mem_kind = exu_pkg::mem_kind_t'(kind);
        o.mem_size = exu_pkg::mem_size_t'(size);
        o.pc_sel   = exu_pkg::pc_sel_t'(psel);
        o.ebreak   = brk;
        return o;
    endfunction

    // expected alu result from the operand and function rules.
    function automatic logic [31:0] ref_alu(input exu_pkg::exu_op_t o,
            input logic [31:0] a_rs1, input logic [31:0] a_rs2,
            input logic [31:0] a_imm, input logic [31:0] a_pc);
        logic [31:0] a;
        logic [31:0] b;
        a = (o.src_sel == exu_pkg::SRC_ZERO_IMM) ? 32'd0 :
            (o.src_sel == exu_pkg::SRC_PC_IMM)   ? a_pc  : a_rs1;
        b = (o.src_sel == exu_pkg::SRC_RS1_RS2) ? a_rs2 : a_imm;
        case (o.alu_fn)
            exu_pkg::ALU_ADD:  return a + b;
            exu_pkg::ALU_SUB:  return a - b;
            exu_pkg::ALU_XOR:  return a ^ b;
            exu_pkg::ALU_OR:   return a | b;
            exu_pkg::ALU_AND:  return a & b;
            exu_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:           return a << b[4:0];
        endcase
    endfunction

    function automatic logic [31:0] ref_next_pc(input exu_pkg::exu_op_t o,
            input logic [31:0] a_rs1, input logic [31:0] a_imm,
            input logic [31:0] a_pc, input logic [31:0] alu);
        case (o.pc_sel)
            exu_pkg::PC_SEQ:    return a_pc + 32'd4;
            exu_pkg::PC_BRANCH: return (alu != 32'd0) ? a_pc + a_imm : a_pc + 32'd4;
            exu_pkg::PC_JAL:    return a_pc + a_imm;
            default:            return (a_rs1 + a_imm) & ~32'd1;
        endcase
    endfunction

    // loads zero-extend the lane bytes.
    function automatic logic [31:0] shadow_load(input logic [7:0] idx, input int sh,
            input int nbytes);
        logic [31:0] word;
        word = shadow[idx] >> (sh * 8);
        if (nbytes == 1) begin
            return {24'd0, word[7:0]};
        end else if (nbytes == 2) begin
            return {16'd0, word[15:0]};
        end
        return word;
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0t: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    // ******************************
    // one op through the handshake.
    // ******************************
    task automatic run_op(input exu_pkg::exu_op_t o, input logic [31:0] a_rs1,
            input logic [31:0] a_rs2, input logic [31:0] a_imm, input logic [31:0] a_pc);
        logic [31:0] alu;
        logic [31:0] exp_rd;
        logic [31:0] exp_pc;
        logic [7:0]  idx;
        int          sh;
        int          nbytes;
        int          hold;
        alu    = ref_alu(o, a_rs1, a_rs2, a_imm, a_pc);
        exp_pc = ref_next_pc(o, a_rs1, a_imm, a_pc, alu);
        exp_rd = alu;
        idx    = alu[9:2];
        sh     = int'(alu[1:0]);
        nbytes = (o.mem_size == exu_pkg::SIZE_BYTE) ? 1 :
                 (o.mem_size == exu_pkg::SIZE_HALF) ? 2 : 4;
        // ebreak wins over any memory access.
        if (o.ebreak) begin
            exp_halt = 1'b1;
            exp_code = a_rs1;
        end else if (o.mem_kind == exu_pkg::MEM_STORE) begin
            for (int b = 0; b < nbytes; b++) begin
                shadow[idx][(sh + b) * 8 +: 8] = a_rs2[b * 8 +: 8];
            end
        end else if (o.mem_kind == exu_pkg::MEM_LOAD) begin
            exp_rd = shadow_load(idx, sh, nbytes);
        end
        @(negedge clk);
        op     = o;
        rs1_d  = a_rs1;
        rs2_d  = a_rs2;
        imm    = a_imm;
        pc     = a_pc;
        op_req = 1'b1;
        do @(negedge clk); while (!op_ack);
        check_word("rd_d", rd_d, exp_rd);
        check_word("dnpc", dnpc, exp_pc);
        check_word("halt", {31'd0, halt}, {31'd0, exp_halt});
        if (exp_halt) begin
            check_word("halt_code", halt_code, exp_code);
        end
        // back-pressure, the monitor watches the held results.
        hold = int'(next_rand() % 32'd4);
        repeat (hold) @(negedge clk);
        op_req = 1'b0;
        // operands are latched, so scrambling them must not matter.
        rs1_d = next_rand();
        rs2_d = next_rand();
        do @(negedge clk); while (op_ack);
    endtask

    task automatic run_random_operands(input exu_pkg::exu_op_t o);
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] x4;
        x1 = next_rand();
        x2 = next_rand();
        x3 = next_rand();
        x4 = next_rand();
        run_op(o, x1, x2, x3, {x4[31:2], 2'b00});
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n  = 1'b0;
        op_req = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        // the data memory clears on reset as well.
        for (int i = 0; i < WORDS; i++) begin
            shadow[i] = 32'd0;
        end
        exp_halt = 1'b0;
        exp_code = 32'd0;
        check_word("op_ack after reset", {31'd0, op_ack}, 32'd0);
        check_word("halt after reset", {31'd0, halt}, 32'd0);
    endtask

    // ******************************
    // handshake monitor.
    // ******************************
    always @(posedge clk) begin
        req_q2 <= req_q1;
        req_q1 <= op_req;
        rst_q1 <= rst_n;
    end

    always @(negedge clk) begin
        if (rst_q1) begin
            if (op_ack && !ack_prev) begin
                assert (req_q1) else begin
                    hs_errors++;
                    $display("at %0t op_ack rose while op_req was low", $time);
                end
            end
            if (!op_ack && ack_prev) begin
                assert (!req_q2) else begin
                    hs_errors++;
                    $display("at %0t op_ack fell before op_req was dropped", $time);
                end
            end
            if (op_ack && ack_prev) begin
                assert (rd_d === rd_prev && dnpc === dnpc_prev) else begin
                    hs_errors++;
                    $display("at %0t results changed while op_ack was high", $time);
                end
            end
        end
        ack_prev  <= op_ack;
        rd_prev   <= rd_d;
        dnpc_prev <= dnpc;
    end

    // hang guard sized for the longest run.
    initial begin
        #(OP_LIMIT * CYCLES_PER_OP * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped answering the handshake");
        $display("STATUS: FAIL");
        $finish;
    end

    // ******************************
    // stimulus.
    // ******************************
    initial begin
        exu_pkg::exu_op_t o;
        logic [31:0]      r;
        logic [31:0]      x1;
        logic [31:0]      x2;
        logic [2:0]       fn;
        logic [31:0]      st_addr [STORES];
        logic [1:0]       st_size [STORES];
        rst_n     = 1'b0;
        op_req    = 1'b0;
        op        = '0;
        rs1_d     = 32'd0;
        rs2_d     = 32'd0;
        imm       = 32'd0;
        pc        = 32'd0;
        rng_state = 32'hf66a_8959;
        errors    = 0;
        checks    = 0;
        apply_reset();

        // every function in every source mode.
        for (int s = 0; s < 4; s++) begin
            for (int f = 0; f < 8; f++) begin
                repeat (3) begin
                    r = next_rand();
                    o = build_op(2'(s), 3'(f), exu_pkg::MEM_NONE, exu_pkg::SIZE_WORD,
                                 r[1:0], 1'b0);
                    run_random_operands(o);
                end
            end
        end

        // next-pc modes, equal operands give untaken branches.
        for (int i = 0; i < 64; i++) begin
            r  = next_rand();
            x1 = next_rand();
            x2 = r[2] ? x1 : next_rand();
            case (r[4:3])
                2'd0:    fn = exu_pkg::ALU_SUB;
                2'd1:    fn = exu_pkg::ALU_XOR;
                2'd2:    fn = exu_pkg::ALU_SLT;
                default: fn = exu_pkg::ALU_SLTU;
            endcase
            o = build_op(exu_pkg::SRC_RS1_RS2, fn, exu_pkg::MEM_NONE, exu_pkg::SIZE_WORD,
                         2'(i % 4), 1'b0);
            run_op(o, x1, x2, next_rand(), {r[31:7], 5'd0, 2'b00});
        end

        // stores of every size into the low 1 KiB.
        for (int i = 0; i < STORES; i++) begin
            r          = next_rand();
            st_size[i] = 2'(r % 32'd3);
            x1         = {22'd0, r[17:8]};
            if (st_size[i] == exu_pkg::SIZE_HALF) begin
                x1 = x1 & ~32'd1;
            end else if (st_size[i] == exu_pkg::SIZE_WORD) begin
                x1 = x1 & ~32'd3;
            end
            st_addr[i] = x1;
            x2 = {26'd0, r[23:20], 2'b00};
            o  = build_op(exu_pkg::SRC_RS1_IMM, exu_pkg::ALU_ADD, exu_pkg::MEM_STORE,
                          st_size[i], r[25:24], 1'b0);
            run_op(o, x1 - x2, next_rand(), x2, {r[31:26], 26'd0});
        end

        // read back each lane and then the whole word.
        for (int i = 0; i < STORES; i++) begin
            o = build_op(exu_pkg::SRC_RS1_IMM, exu_pkg::ALU_ADD, exu_pkg::MEM_LOAD,
                         st_size[i], exu_pkg::PC_SEQ, 1'b0);
            run_op(o, st_addr[i], next_rand(), 32'd0, 32'h0000_1000);
            o.mem_size = exu_pkg::SIZE_WORD;
            run_op(o, st_addr[i] & ~32'd3, next_rand(), 32'd0, 32'h0000_1004);
        end

        // ebreak sets a sticky halt and skips memory.
        repeat (2) begin
            r = next_rand();
            o = build_op(r[1:0], r[4:2], 2'(r[7:5] % 3'd3), exu_pkg::SIZE_WORD,
                         r[9:8], 1'b1);
            run_random_operands(o);
        end
        repeat (6) begin
            r = next_rand();
            o = build_op(exu_pkg::SRC_RS1_IMM, exu_pkg::ALU_ADD, exu_pkg::MEM_LOAD,
                         exu_pkg::SIZE_WORD, r[1:0], 1'b0);
            run_op(o, {22'd0, r[11:4], 2'b00}, next_rand(), 32'd0, 32'h0000_2000);
        end

        // a second reset clears the halt.
        apply_reset();
        repeat (4) begin
            r = next_rand();
            o = build_op(r[1:0], r[4:2], exu_pkg::MEM_NONE, exu_pkg::SIZE_WORD,
                         r[6:5], 1'b0);
            run_random_operands(o);
        end

        repeat (4) @(negedge clk);
        $display("checks %0d, value errors %0d, handshake errors %0d",
                 checks, errors, hs_errors);
        if (errors == 0 && hs_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
